// File: src/busPkg.sv
`default_nettype none

package busPkg;

	// Word carried on the bus.
	typedef logic [31:0] busWord;

	// Product or quotient pair from the ALU, high half first.
	typedef logic [63:0] aluWide;

	// Bus select code.
	typedef logic [4:0] selCode;

	// Number of sources that can drive the bus.
	localparam int sourceCount = 24;

	// Code when no strobe is set.
	localparam selCode selNone = 5'd31;

	// Source index order on the bus.
	typedef enum selCode {
		srcR0,
		srcR1,
		srcR2,
		srcR3,
		srcR4,
		srcR5,
		srcR6,
		srcR7,
		srcR8,
		srcR9,
		srcR10,
		srcR11,
		srcR12,
		srcR13,
		srcR14,
		srcR15,
		srcHi,
		srcLo,
		srcZHi,
		srcZLo,
		srcPc,
		srcMdr,
		srcInPort,
		srcC
	} busSource;

	// Declared from the top index down, so bit i is busSource i.
	typedef struct packed {
		logic cOut;
		logic inPortOut;
		logic mdrOut;
		logic pcOut;
		logic zLoOut;
		logic zHiOut;
		logic loOut;
		logic hiOut;
		logic r15Out;
		logic r14Out;
		logic r13Out;
		logic r12Out;
		logic r11Out;
		logic r10Out;
		logic r9Out;
		logic r8Out;
		logic r7Out;
		logic r6Out;
		logic r5Out;
		logic r4Out;
		logic r3Out;
		logic r2Out;
		logic r1Out;
		logic r0Out;
	} outStrobes;

	// Load levels of the special registers.
	typedef struct packed {
		logic hiIn;
		logic loIn;
		logic zIn;
		logic pcIn;
		logic mdrIn;
		logic mdrRead;
	} specialIn;

	// Contents of the special registers as seen by the bus.
	typedef struct packed {
		busWord hi;
		busWord lo;
		busWord zHi;
		busWord zLo;
		busWord pc;
		busWord mdr;
		busWord inPort;
	} specialWords;

endpackage

`default_nettype wire

// File: src/busEncoder.sv
`timescale 1ns/100ps
`default_nettype none

module busEncoder
	import busPkg::*;
(
	input outStrobes outSel,
	output selCode code
);

	// Strobes as a plain vector, indexed by busSource.
	logic [sourceCount-1:0] strobeBits;

	// Set once a strobe has been taken.
	logic found;

	assign strobeBits = outSel;

	// Scan upward, first strobe set wins.
	always_comb begin
		code = selNone;
		found = 1'b0;
		for (int i = 0; i < sourceCount; i++) begin
			if (strobeBits[i] && !found) begin
				code = selCode'(i);
				found = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/busMultiplexer.sv
`timescale 1ns/100ps
`default_nettype none

module busMultiplexer
	import busPkg::*;
#(
	parameter int regCount = 16
) (
	input selCode code,
	input busWord regWords [regCount],
	input specialWords spWords,
	input busWord cSignExtended,
	output busWord busValue
);

	localparam int idxWidth = $clog2(regCount);

	// Register index taken from the low bits of the code.
	logic [idxWidth-1:0] regIdx;

	// High when the code names a register that exists.
	logic regValid;

	assign regIdx = code[idxWidth-1:0];
	assign regValid = int'(code) < regCount;

	always_comb begin
		busValue = '0;
		case (code)
			srcR0,
			srcR1,
			srcR2,
			srcR3,
			srcR4,
			srcR5,
			srcR6,
			srcR7,
			srcR8,
			srcR9,
			srcR10,
			srcR11,
			srcR12,
			srcR13,
			srcR14,
			srcR15: begin
				// Codes past the register count read zero.
				if (regValid) begin
					busValue = regWords[regIdx];
				end
			end
			srcHi: begin
				busValue = spWords.hi;
			end
			srcLo: begin
				busValue = spWords.lo;
			end
			srcZHi: begin
				busValue = spWords.zHi;
			end
			srcZLo: begin
				busValue = spWords.zLo;
			end
			srcPc: begin
				busValue = spWords.pc;
			end
			srcMdr: begin
				busValue = spWords.mdr;
			end
			srcInPort: begin
				busValue = spWords.inPort;
			end
			srcC: begin
				busValue = cSignExtended;
			end
			// Idle bus, selNone included.
			default: begin
				busValue = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile
	import busPkg::*;
#(
	parameter int regCount = 16
) (
	input logic clk,
	input logic arstN,
	input logic [regCount-1:0] regIn,
	input busWord busValue,
	output busWord regWords [regCount]
);

	// General registers R0 upward.
	busWord regs [regCount];

	// Any number of registers may load in the same cycle.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (regIn[i]) begin
					regs[i] <= busValue;
				end
			end
		end
	end

	assign regWords = regs;

endmodule

`default_nettype wire

// File: src/specialRegisters.sv
`timescale 1ns/100ps
`default_nettype none

module specialRegisters
	import busPkg::*;
(
	input logic clk,
	input logic arstN,
	input specialIn spIn,
	input busWord busValue,
	input busWord inPortData,
	input busWord memData,
	input aluWide aluResult,
	output specialWords spWords
);

	busWord hiReg;
	busWord loReg;
	busWord zHiReg;
	busWord zLoReg;
	busWord pcReg;
	busWord mdrReg;
	busWord inPortReg;

	// HI, LO and PC load from the bus.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hiReg <= '0;
			loReg <= '0;
			pcReg <= '0;
		end else begin
			if (spIn.hiIn) begin
				hiReg <= busValue;
			end
			if (spIn.loIn) begin
				loReg <= busValue;
			end
			if (spIn.pcIn) begin
				pcReg <= busValue;
			end
		end
	end

	// Memory read takes precedence over a bus load.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mdrReg <= '0;
		end else if (spIn.mdrRead) begin
			mdrReg <= memData;
		end else if (spIn.mdrIn) begin
			mdrReg <= busValue;
		end
	end

	// Result register halves straight from the ALU.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			zHiReg <= '0;
			zLoReg <= '0;
		end else if (spIn.zIn) begin
			zHiReg <= aluResult[63:32];
			zLoReg <= aluResult[31:0];
		end
	end

	// Input port samples every edge.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			inPortReg <= '0;
		end else begin
			inPortReg <= inPortData;
		end
	end

	assign spWords = '{
		hi: hiReg,
		lo: loReg,
		zHi: zHiReg,
		zLo: zLoReg,
		pc: pcReg,
		mdr: mdrReg,
		inPort: inPortReg
	};

endmodule

`default_nettype wire

// File: src/busDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module busDatapath
	import busPkg::*;
#(
	parameter int regCount = 16
) (
	input logic clk,
	input logic arstN,
	input outStrobes outSel,
	input logic [regCount-1:0] regIn,
	input specialIn spIn,
	input busWord inPortData,
	input busWord memData,
	input busWord cSignExtended,
	input aluWide aluResult,
	output busWord busValue
);

	// Select code from the strobes.
	selCode code;

	// Register contents feeding the multiplexer.
	busWord regWords [regCount];
	specialWords spWords;

	busEncoder encoder (
		.outSel(outSel),
		.code(code)
	);

	busMultiplexer #(
		.regCount(regCount)
	) mux (
		.code(code),
		.regWords(regWords),
		.spWords(spWords),
		.cSignExtended(cSignExtended),
		.busValue(busValue)
	);

	// Both register blocks load from the bus value settled before the edge.
	registerFile #(
		.regCount(regCount)
	) regFile (
		.clk(clk),
		.arstN(arstN),
		.regIn(regIn),
		.busValue(busValue),
		.regWords(regWords)
	);

	specialRegisters spRegs (
		.clk(clk),
		.arstN(arstN),
		.spIn(spIn),
		.busValue(busValue),
		.inPortData(inPortData),
		.memData(memData),
		.aluResult(aluResult),
		.spWords(spWords)
	);

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter int periodNs = 40,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever begin
			#(periodNs / 2);
			clk = ~clk;
		end
	end

	// Released on a falling edge, away from the register clock edge.
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN <= 1'b1;
	end

endmodule

`default_nettype wire

// File: test/busDatapath_sva.sv
`timescale 1ns/100ps
`default_nettype none

module busDatapathSva
	import busPkg::*;
(
	input logic clk,
	input logic arstN,
	input outStrobes outSel,
	input selCode code,
	input busWord busValue
);

	// No source exactly when no strobe is set.
	idleCode: assert property (@(posedge clk) (outSel == '0) == (code == selNone))
		else $error("Select code %0d does not match strobes %h", code, outSel);

	// Idle code leaves the bus at zero.
	idleBus: assert property (@(posedge clk) (code == selNone) |-> (busValue == '0))
		else $error("Bus is %h with no source selected", busValue);

	// Cleared registers read zero on the bus while reset is held.
	resetBus: assert property (@(posedge clk) (!arstN && !outSel.cOut) |-> (busValue == '0))
		else $error("Bus is %h during reset with source code %0d", busValue, code);

endmodule

bind busDatapath busDatapathSva sva (
	.clk(clk),
	.arstN(arstN),
	.outSel(outSel),
	.code(code),
	.busValue(busValue)
);

`default_nettype wire

// File: test/busDatapathTb.sv
`timescale 1ns/100ps
`default_nettype none

module busDatapathTb
	import busPkg::*;
();

	localparam int clkPeriod = 40;
	localparam int resetCycles = 4;
	localparam int sampleLead = 2;
	localparam int resetTimeout = 20;
	localparam int maxLines = 512;
	localparam string stimulusPath = "test/bus_stimulus.hex";

	logic clk;
	logic arstN;
	outStrobes outSel;
	logic [15:0] regIn;
	specialIn spIn;
	busWord inPortData;
	busWord memData;
	busWord cSignExtended;
	aluWide aluResult;
	busWord busValue;

	int errorCount;
	int vectorCount;

	clockGen #(
		.periodNs(clkPeriod),
		.resetCycles(resetCycles)
	) clockSource (
		.clk(clk),
		.arstN(arstN)
	);

	busDatapath #(
		.regCount(16)
	) UUT (
		.clk(clk),
		.arstN(arstN),
		.outSel(outSel),
		.regIn(regIn),
		.spIn(spIn),
		.inPortData(inPortData),
		.memData(memData),
		.cSignExtended(cSignExtended),
		.aluResult(aluResult),
		.busValue(busValue)
	);

	task automatic compareWord(input string name, input busWord actual, input busWord expected);
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s is %h, expected %h at vector %0d",
				name, actual, expected, vectorCount);
		end
	endtask

	// One vector per cycle, bus checked just before the rising edge.
	task automatic applyVector(
		input logic [23:0] strobeField,
		input logic [15:0] regField,
		input logic [7:0] spField,
		input busWord inPortField,
		input busWord memField,
		input busWord cField,
		input aluWide aluField,
		input busWord expected
	);
		@(negedge clk);
		outSel = outStrobes'(strobeField);
		regIn = regField;
		spIn = specialIn'(spField[5:0]);
		inPortData = inPortField;
		memData = memField;
		cSignExtended = cField;
		aluResult = aluField;
		#(clkPeriod / 2 - sampleLead);
		vectorCount++;
		compareWord("busValue", busValue, expected);
	endtask

	task automatic waitForReset(output bit released);
		int waited;
		waited = 0;
		while (arstN !== 1'b1 && waited < resetTimeout) begin
			@(negedge clk);
			// Special registers in turn, all cleared while reset holds.
			outSel = outStrobes'(24'(1) << (int'(srcHi) + waited));
			waited++;
		end
		outSel = '0;
		released = (arstN === 1'b1);
		if (!released) begin
			errorCount++;
			$display("Reset was still active after %0d cycles", resetTimeout);
		end
	endtask

	task automatic runStimulus();
		int fd;
		int n;
		int lineCount;
		string line;
		logic [23:0] strobeField;
		logic [15:0] regField;
		logic [7:0] spField;
		busWord inPortField;
		busWord memField;
		busWord cField;
		aluWide aluField;
		busWord expected;
		fd = $fopen(stimulusPath, "r");
		if (fd == 0) begin
			errorCount++;
			$display("Could not open the stimulus file %s", stimulusPath);
			return;
		end
		lineCount = 0;
		while (!$feof(fd) && lineCount < maxLines) begin
			n = $fgets(line, fd);
			lineCount++;
			// Skip comment lines.
			if (n > 0 && line.substr(0, 1) != "//") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h", strobeField, regField, spField,
					inPortField, memField, cField, aluField, expected);
				if (n == 8) begin
					applyVector(strobeField, regField, spField, inPortField, memField,
						cField, aluField, expected);
				end else if (line.len() > 1) begin
					errorCount++;
					$display("Stimulus line %0d could not be read", lineCount);
				end
			end
		end
		if (!$feof(fd)) begin
			errorCount++;
			$display("Stimulus file did not end within %0d lines", maxLines);
		end
		$fclose(fd);
		if (vectorCount == 0) begin
			errorCount++;
			$display("Stimulus file held no vectors");
		end
	endtask

	initial begin
		bit released;
		outSel = '0;
		regIn = '0;
		spIn = '0;
		inPortData = '0;
		memData = '0;
		cSignExtended = '0;
		aluResult = '0;
		errorCount = 0;
		vectorCount = 0;
		waitForReset(released);
		if (released) begin
			runStimulus();
		end
		$display("Vectors checked: %0d, errors: %0d", vectorCount, errorCount);
		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: busDatapath.f
src/busPkg.sv
src/busEncoder.sv
src/busMultiplexer.sv
src/registerFile.sv
src/specialRegisters.sv
src/busDatapath.sv
test/clockGen.sv
test/busDatapath_sva.sv
test/busDatapathTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = busDatapathTb
FILELIST = busDatapath.f
BUILD = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/bus_stimulus.hex
// outSel regIn spIn inPortData memData cSignExtended aluResult expectedBus
// spIn bits from the top are hiIn loIn zIn pcIn mdrIn mdrRead
000000 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000001 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000002 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000004 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000008 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000010 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000020 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000040 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000080 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000100 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000200 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000400 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000800 0000 00 00000000 00000000 00000000 0000000000000000 00000000
001000 0000 00 00000000 00000000 00000000 0000000000000000 00000000
002000 0000 00 00000000 00000000 00000000 0000000000000000 00000000
004000 0000 00 00000000 00000000 00000000 0000000000000000 00000000
008000 0000 00 00000000 00000000 00000000 0000000000000000 00000000
800000 0001 00 00000000 00000000 00005A5A 0000000000000000 00005A5A
800000 0002 00 00000000 00000000 11115A5A 0000000000000000 11115A5A
800000 0004 00 00000000 00000000 22225A5A 0000000000000000 22225A5A
800000 0008 00 00000000 00000000 33335A5A 0000000000000000 33335A5A
800000 0010 00 00000000 00000000 44445A5A 0000000000000000 44445A5A
800000 0020 00 00000000 00000000 55555A5A 0000000000000000 55555A5A
800000 0040 00 00000000 00000000 66665A5A 0000000000000000 66665A5A
800000 0080 00 00000000 00000000 77775A5A 0000000000000000 77775A5A
800000 0100 00 00000000 00000000 88885A5A 0000000000000000 88885A5A
800000 0200 00 00000000 00000000 99995A5A 0000000000000000 99995A5A
800000 0400 00 00000000 00000000 AAAA5A5A 0000000000000000 AAAA5A5A
800000 0800 00 00000000 00000000 BBBB5A5A 0000000000000000 BBBB5A5A
800000 1000 00 00000000 00000000 CCCC5A5A 0000000000000000 CCCC5A5A
800000 2000 00 00000000 00000000 DDDD5A5A 0000000000000000 DDDD5A5A
800000 4000 00 00000000 00000000 EEEE5A5A 0000000000000000 EEEE5A5A
800000 8000 00 00000000 00000000 FFFF5A5A 0000000000000000 FFFF5A5A
000001 0000 00 00000000 00000000 00000000 0000000000000000 00005A5A
000002 0000 00 00000000 00000000 00000000 0000000000000000 11115A5A
000004 0000 00 00000000 00000000 00000000 0000000000000000 22225A5A
000008 0000 00 00000000 00000000 00000000 0000000000000000 33335A5A
000010 0000 00 00000000 00000000 00000000 0000000000000000 44445A5A
000020 0000 00 00000000 00000000 00000000 0000000000000000 55555A5A
000040 0000 00 00000000 00000000 00000000 0000000000000000 66665A5A
000080 0000 00 00000000 00000000 00000000 0000000000000000 77775A5A
000100 0000 00 00000000 00000000 00000000 0000000000000000 88885A5A
000200 0000 00 00000000 00000000 00000000 0000000000000000 99995A5A
000400 0000 00 00000000 00000000 00000000 0000000000000000 AAAA5A5A
000800 0000 00 00000000 00000000 00000000 0000000000000000 BBBB5A5A
001000 0000 00 00000000 00000000 00000000 0000000000000000 CCCC5A5A
002000 0000 00 00000000 00000000 00000000 0000000000000000 DDDD5A5A
004000 0000 00 00000000 00000000 00000000 0000000000000000 EEEE5A5A
008000 0000 00 00000000 00000000 00000000 0000000000000000 FFFF5A5A
800000 0000 20 00000000 00000000 12345678 0000000000000000 12345678
800000 0000 10 00000000 00000000 9ABCDEF0 0000000000000000 9ABCDEF0
800000 0000 04 00000000 00000000 00400080 0000000000000000 00400080
800000 0000 02 00000000 00000000 DEADBEEF 0000000000000000 DEADBEEF
010000 0000 00 00000000 00000000 00000000 0000000000000000 12345678
020000 0000 00 00000000 00000000 00000000 0000000000000000 9ABCDEF0
100000 0000 00 00000000 00000000 00000000 0000000000000000 00400080
200000 0000 01 00000000 CAFEF00D 00000000 0000000000000000 DEADBEEF
200000 0000 00 00000000 00000000 00000000 0000000000000000 CAFEF00D
800000 0000 03 00000000 0BADF00D 11112222 0000000000000000 11112222
200000 0000 00 00000000 00000000 00000000 0000000000000000 0BADF00D
000000 0000 08 13579BDF 00000000 00000000 0123456789ABCDEF 00000000
040000 0000 00 13579BDF 00000000 00000000 FFFFFFFFFFFFFFFF 01234567
080000 0000 00 2468ACE0 00000000 00000000 FFFFFFFFFFFFFFFF 89ABCDEF
400000 0000 00 00000000 00000000 00000000 0000000000000000 2468ACE0
400000 0000 00 00000000 00000000 00000000 0000000000000000 00000000
010008 0000 00 00000000 00000000 00000000 0000000000000000 33335A5A
810000 0000 00 00000000 00000000 77777777 0000000000000000 12345678
008002 0000 00 00000000 00000000 00000000 0000000000000000 11115A5A
000000 0000 00 00000000 00000000 00000000 0000000000000000 00000000
000008 0080 00 00000000 00000000 00000000 0000000000000000 33335A5A
000080 0000 00 00000000 00000000 00000000 0000000000000000 33335A5A
000008 0000 00 00000000 00000000 00000000 0000000000000000 33335A5A
